//--- flist.f
+incdir+sim
common/exec_pkg.sv
alu/int_alu.sv
lsu/lsu_agu.sv
trap/csr_file.sv
trap/trap_ctrl.sv
design/execute_top.sv
sim/tb_execute.sv

//--- Makefile
BIN  := obj_dir/Vtb_execute
SRCS := $(filter-out +incdir+%,$(shell cat flist.f))

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "sim passed" sim.log

$(BIN): flist.f $(SRCS) sim/tb_model.svh
	verilator --binary --timing -j 0 --top-module tb_execute -f flist.f

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference copy of the configuration registers
logic [3:0]  m_status;
logic [3:0]  m_estatus;
logic [3:0]  m_ecause;
logic [31:0] m_epc;
logic [31:0] m_edata;
logic [31:0] m_escratch;
logic        m_jump;                    // Registered jump of the last slot
logic [31:0] m_p4;                      // Registered result seen by the stage 4 bypass
logic [31:0] rng_state = 32'd85;

function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// One slot of the stage with mem_req now and result one cycle later
function automatic void predict(
    input  logic        rst,
    input  issue_t      iss,
    input  bypass_t     byp,
    input  logic [31:0] p5,
    output mem_req_t    exp_mem,
    output result_t     exp_res,
    output logic        exp_super
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] rd;
    logic [1:0]  size;
    int          nbytes;
    logic        kill;
    logic        is_load;
    logic        is_store;
    logic        bad;
    logic        taken;
    logic        illegal;
    logic        align;
    logic        sys;
    logic        exc;
    logic        rte;

    kill     = rst || m_jump;
    a        = byp.a4 ? m_p4 : (byp.a5 ? p5 : iss.data_a);
    b        = byp.b4 ? m_p4 : (byp.b5 ? p5 : iss.data_b);
    addr     = a + iss.literal;
    is_load  = iss.op inside {OP_LDB, OP_LDH, OP_LDW};
    is_store = iss.op inside {OP_STB, OP_STH, OP_STW};
    size     = 2'd0;
    if (iss.op inside {OP_LDH, OP_STH}) size = 2'd1;
    if (iss.op inside {OP_LDW, OP_STW}) size = 2'd2;
    nbytes = 1 << size;
    bad = (size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'd0);

    case (iss.op)
        OP_AND:   value = a & b;
        OP_OR:    value = a | b;
        OP_XOR:   value = a ^ b;
        OP_ADD:   value = a + b;
        OP_SUB:   value = a - b;
        OP_CLT:   value = {31'd0, $signed(a) < $signed(b)};
        OP_CLTU:  value = {31'd0, a < b};
        OP_LDIMM: value = iss.literal;
        OP_LDPC:  value = iss.pc + iss.literal;
        OP_JAL,
        OP_JALR:  value = iss.pc;
        OP_SHIFT: begin
            case (iss.literal[6:5])
                2'b00:   value = a << b[4:0];
                2'b10:   value = a >> b[4:0];
                2'b11:   value = $signed(a) >>> b[4:0];
                default: value = 32'd0;     // Unused shift kind
            endcase
        end
        default:  value = 32'd0;
    endcase

    case (iss.op)
        OP_BEQ:  taken = (a == b);
        OP_BNE:  taken = (a != b);
        OP_BLT:  taken = $signed(a) < $signed(b);
        OP_BGE:  taken = $signed(a) >= $signed(b);
        OP_BLTU: taken = a < b;
        OP_BGEU: taken = a >= b;
        OP_JAL,
        OP_JALR: taken = 1'b1;
        default: taken = 1'b0;
    endcase

    case (iss.literal[15:0])
        CFG_ADDR_VERSION:  rd = 32'h0001_0000;
        CFG_ADDR_EPC:      rd = m_epc;
        CFG_ADDR_ECAUSE:   rd = {28'd0, m_ecause};
        CFG_ADDR_EDATA:    rd = m_edata;
        CFG_ADDR_ESTATUS:  rd = {28'd0, m_estatus};
        CFG_ADDR_ESCRATCH: rd = m_escratch;
        default:           rd = 32'd0;
    endcase

    illegal = !kill && iss.op == OP_ILLEGAL;
    align   = !kill && (is_load || is_store) && bad;
    sys     = !kill && iss.op == OP_SYSCALL;
    exc     = illegal || align || sys;
    rte     = !kill && iss.op == OP_RTE;

    exp_mem         = '0;
    exp_mem.request = (is_load || is_store) && !bad && !kill && !exc;
    exp_mem.write   = is_store;
    exp_mem.addr    = addr;
    if (is_store) begin
        for (int lane = 0; lane < 4; lane++) begin
            // Each lane repeats the low bytes of b and only the accessed lanes are strobed
            exp_mem.wdata.store_data[8*lane +: 8] = b[8*(lane % nbytes) +: 8];
            exp_mem.wstrb[lane] = (lane / nbytes) == (addr[1:0] / nbytes);
        end
    end else begin
        exp_mem.wdata.load_tag.size        = size;
        exp_mem.wdata.load_tag.offset      = addr[1:0];
        exp_mem.wdata.load_tag.latent_dest = iss.latent_dest;
    end

    exp_res.op = iss.op;
    if (iss.op inside {OP_CFGR, OP_CFGW}) exp_res.alu_result = rd;
    else if (is_store) exp_res.alu_result = b;
    else exp_res.alu_result = value;
    exp_res.jump      = exc || rte || (!kill && taken);
    exp_res.jump_addr = exc ? EXC_VECTOR : (rte ? m_epc : iss.pc + iss.literal);
    if (!exc && !rte && iss.op == OP_JALR) exp_res.jump_addr = a + iss.literal;
    exp_res.dest      = (kill || exc || iss.op == OP_NOP) ? 5'd0 : iss.dest;
    exp_res.dest_zero = (exp_res.dest == 5'd0);

    if (rst) begin
        m_status   = 4'b0001;
        m_estatus  = 4'd0;
        m_ecause   = 4'd0;
        m_epc      = 32'd0;
        m_edata    = 32'd0;
        m_escratch = 32'd0;
    end else if (exc) begin
        m_ecause  = illegal ? CAUSE_ILLEGAL_INSTR : (align ? (is_store ?
                    CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED) : CAUSE_SYSCALL);
        m_edata   = illegal ? iss.instr : (align ? addr : iss.literal);
        m_epc     = iss.pc - 32'd4;
        m_estatus = m_status;
        m_status  = m_status | 4'b0001;
    end else if (rte) begin
        m_status = m_estatus;
    end else if (!kill && iss.op == OP_CFGW) begin
        case (iss.literal[15:0])
            CFG_ADDR_EPC:      m_epc      = a;
            CFG_ADDR_ECAUSE:   m_ecause   = a[3:0];
            CFG_ADDR_EDATA:    m_edata    = a;
            CFG_ADDR_ESTATUS:  m_estatus  = a[3:0];
            CFG_ADDR_ESCRATCH: m_escratch = a;
            default:           ;
        endcase
    end
    m_jump    = exp_res.jump;
    m_p4      = exp_res.alu_result;
    exp_super = m_status[0];
endfunction

`endif

//--- sim/tb_execute.sv
module tb_execute;
    import exec_pkg::*;

    localparam logic [31:0] EXC_VECTOR   = 32'h0000_0100;
    localparam int          RANDOM_OPS   = 400;
    localparam int          DIRECTED_OPS = 100;
    localparam int          TEST_CYCLES  = 5 + RANDOM_OPS + DIRECTED_OPS;
    localparam bypass_t     NO_BYPASS    = '0;

    logic        clock;
    logic        reset;
    logic        reset_hold;
    issue_t      issue;
    bypass_t     bypass;
    logic [31:0] p5_result;
    mem_req_t    mem_req;
    result_t     result;
    logic        supervisor_mode;

    logic [31:0] pc_next;
    mem_req_t    mem_q[$];
    result_t     res_q[$];
    logic        super_q[$];
    int          errors = 0;
    int          checks = 0;

    `include "tb_model.svh"

    execute_top #(
        .EXC_VECTOR (EXC_VECTOR)
    ) execute_top_i (
        .clock           (clock),
        .reset           (reset),
        .issue           (issue),
        .bypass          (bypass),
        .p5_result       (p5_result),
        .mem_req         (mem_req),
        .result          (result),
        .supervisor_mode (supervisor_mode)
    );

    initial begin
        clock = 1'b1;
        forever #5 clock = ~clock;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error %s expected %h got %h", name, expected, got);
        end
    endtask

    // Present one instruction on the falling edge and queue its expectations
    task automatic send(input op_e op, input logic [31:0] literal,
                        input logic [31:0] data_a, input logic [31:0] data_b,
                        input logic [4:0] dest, input bypass_t byp);
        mem_req_t    exp_mem;
        result_t     exp_res;
        logic        exp_super;
        logic [31:0] r;
        @(negedge clock);
        r                 = xorshift();
        reset             = reset_hold;
        issue.pc          = pc_next;
        issue.instr       = xorshift();
        issue.op          = op;
        issue.literal     = literal;
        issue.dest        = dest;
        issue.latent_dest = r[4:0];
        issue.data_a      = data_a;
        issue.data_b      = data_b;
        bypass            = byp;
        p5_result         = xorshift();
        pc_next           = pc_next + 32'd4;
        predict(reset, issue, bypass, p5_result, exp_mem, exp_res, exp_super);
        mem_q.push_back(exp_mem);
        res_q.push_back(exp_res);
        super_q.push_back(exp_super);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) send(OP_NOP, '0, '0, '0, 5'd0, NO_BYPASS);
    endtask

    task automatic read_cfg(input logic [15:0] addr);
        send(OP_CFGR, {16'd0, addr}, '0, '0, 5'd7, NO_BYPASS);
    endtask

    task automatic write_cfg(input logic [15:0] addr, input logic [31:0] value);
        send(OP_CFGW, {16'd0, addr}, value, '0, 5'd8, NO_BYPASS);
    endtask

    function automatic op_e random_op();
        logic [31:0] r;
        logic [5:0]  code;
        code = 6'h3d;                               // Not an opcode
        while (!(code inside {[6'h00:6'h09], [6'h10:6'h12], [6'h18:6'h1a],
                              [6'h20:6'h27], [6'h30:6'h33], 6'h3e, 6'h3f})) begin
            r    = xorshift();
            code = r[13:8];
        end
        return op_e'(code);
    endfunction

    // mem_req is checked in its own slot and result one slot later
    initial begin
        mem_req_t exp_mem;
        result_t  exp_res;
        logic     exp_super;
        logic     armed;
        armed = 1'b0;
        forever begin
            @(negedge clock);
            #2;
            if (mem_q.size() > 0) begin
                exp_mem = mem_q.pop_front();
                compare("mem_req.request", 32'(exp_mem.request), 32'(mem_req.request));
                if (exp_mem.request) begin
                    compare("mem_req.write", 32'(exp_mem.write), 32'(mem_req.write));
                    compare("mem_req.addr", exp_mem.addr, mem_req.addr);
                    compare("mem_req.wdata", exp_mem.wdata, mem_req.wdata);
                    compare("mem_req.wstrb", 32'(exp_mem.wstrb), 32'(mem_req.wstrb));
                end
            end
            if (armed) begin
                compare("result.op", 32'(exp_res.op), 32'(result.op));
                compare("result.dest", 32'(exp_res.dest), 32'(result.dest));
                compare("result.dest_zero", 32'(exp_res.dest_zero), 32'(result.dest_zero));
                compare("result.alu_result", exp_res.alu_result, result.alu_result);
                compare("result.jump", 32'(exp_res.jump), 32'(result.jump));
                if (exp_res.jump) begin
                    compare("result.jump_addr", exp_res.jump_addr, result.jump_addr);
                end
                compare("supervisor_mode", 32'(exp_super), 32'(supervisor_mode));
            end
            if (res_q.size() > 0) begin
                exp_res   = res_q.pop_front();
                exp_super = super_q.pop_front();
                armed     = 1'b1;
            end
        end
    end

    initial begin
        #(TEST_CYCLES * 10 + 500);
        $display("Timeout: the run did not finish within %0d time units",
                 TEST_CYCLES * 10 + 500);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] base;
        logic [31:0] data;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] lit;
        op_e         op;

        reset      = 1'b1;
        reset_hold = 1'b1;
        issue      = '0;
        issue.op   = OP_NOP;
        bypass     = NO_BYPASS;
        p5_result  = '0;
        pc_next    = 32'h0000_1000;

        // Five reset cycles with live instructions that must have no effect
        send(OP_LDW, '0, 32'h0000_0040, '0, 5'd1, NO_BYPASS);
        send(OP_STW, '0, 32'h0000_0040, 32'h1234_5678, 5'd2, NO_BYPASS);
        send(OP_SYSCALL, 32'h0000_0001, '0, '0, 5'd3, NO_BYPASS);
        send(OP_JAL, 32'h0000_0040, '0, '0, 5'd4, NO_BYPASS);
        send(OP_ILLEGAL, '0, '0, '0, 5'd5, NO_BYPASS);
        reset_hold = 1'b0;

        for (int n = 0; n < RANDOM_OPS; n++) begin
            op  = random_op();
            r   = xorshift();
            a   = xorshift();
            b   = xorshift();
            lit = xorshift();
            if (r[0]) begin
                b = a;                              // Equal operands for branches
            end
            if (op inside {OP_CFGR, OP_CFGW}) begin
                lit = {29'd0, r[3:1]};
            end
            send(op, lit, a, b, r[8:4], bypass_t'(r[12:9]));
        end
        idle(2);

        base = xorshift() & 32'hffff_fff0;
        data = xorshift();
        for (int off = 0; off < 4; off++) begin
            lit = 32'(off);
            send(OP_STB, lit, base, data, 5'd0, NO_BYPASS);
            send(OP_STH, lit, base, data, 5'd0, NO_BYPASS);
            idle(1);                                // May be killed by a trap
            send(OP_STW, lit, base, data, 5'd0, NO_BYPASS);
            idle(1);
            send(OP_LDB, lit, base, '0, 5'd3, NO_BYPASS);
            send(OP_LDH, lit, base, '0, 5'd3, NO_BYPASS);
            idle(1);
            send(OP_LDW, lit, base, '0, 5'd3, NO_BYPASS);
            idle(1);
        end

        send(OP_LDH, 32'd3, base, data, 5'd4, NO_BYPASS);
        idle(1);
        read_cfg(CFG_ADDR_ECAUSE);
        read_cfg(CFG_ADDR_EDATA);
        read_cfg(CFG_ADDR_EPC);
        send(OP_STW, 32'd6, base, data, 5'd0, NO_BYPASS);
        idle(1);
        read_cfg(CFG_ADDR_ECAUSE);
        read_cfg(CFG_ADDR_EDATA);
        read_cfg(CFG_ADDR_EPC);

        write_cfg(CFG_ADDR_ESTATUS, 32'd0);
        send(OP_RTE, '0, '0, '0, 5'd0, NO_BYPASS);
        idle(2);                                    // User mode from here
        send(OP_SYSCALL, 32'h0000_0a5c, '0, '0, 5'd9, NO_BYPASS);
        idle(1);
        read_cfg(CFG_ADDR_EDATA);
        read_cfg(CFG_ADDR_ESTATUS);
        read_cfg(CFG_ADDR_ECAUSE);
        write_cfg(CFG_ADDR_ESCRATCH, data);
        read_cfg(CFG_ADDR_ESCRATCH);
        write_cfg(CFG_ADDR_VERSION, data);
        read_cfg(CFG_ADDR_VERSION);
        send(OP_ILLEGAL, '0, '0, '0, 5'd9, NO_BYPASS);
        idle(1);
        read_cfg(CFG_ADDR_EDATA);
        read_cfg(CFG_ADDR_ECAUSE);

        send(OP_JAL, 32'h0000_0040, '0, '0, 5'd1, NO_BYPASS);
        send(OP_STW, '0, base, data, 5'd2, NO_BYPASS);
        send(OP_JALR, 32'h0000_0010, base, '0, 5'd3, NO_BYPASS);
        send(OP_SYSCALL, 32'h0000_1234, '0, '0, 5'd4, NO_BYPASS);
        read_cfg(CFG_ADDR_EDATA);
        send(OP_BEQ, 32'h0000_0020, data, data, 5'd5, NO_BYPASS);
        write_cfg(CFG_ADDR_ESCRATCH, ~data);
        read_cfg(CFG_ADDR_ESCRATCH);
        send(OP_BNE, 32'h0000_0020, data, data, 5'd5, NO_BYPASS);
        send(OP_ADD, '0, data, base, 5'd6, NO_BYPASS);
        idle(3);
        #4;

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- design/execute_top.sv
module execute_top #(
    parameter logic [exec_pkg::XLEN-1:0] EXC_VECTOR = 32'h0000_0100
) (
    input  logic                      clock,
    input  logic                      reset,
    input  exec_pkg::issue_t          issue,
    input  exec_pkg::bypass_t         bypass,
    input  logic [exec_pkg::XLEN-1:0] p5_result,
    output exec_pkg::mem_req_t        mem_req,
    output exec_pkg::result_t         result,
    output logic                      supervisor_mode
);
    import exec_pkg::*;

    operands_t       operands;
    logic [XLEN-1:0] alu_value;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    mem_req_t        raw_mem;
    logic            misaligned;
    logic [XLEN-1:0] read_value;
    logic [XLEN-1:0] epc;
    trap_cmd_t       trap_cmd;
    logic            write_en;

    int_alu int_alu_i (
        .issue         (issue),
        .bypass        (bypass),
        .p4_alu_result (result.alu_result),    // Own registered result
        .p5_result     (p5_result),
        .operands      (operands),
        .alu_value     (alu_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    lsu_agu lsu_agu_i (
        .op         (issue.op),
        .literal    (issue.literal),
        .operands   (operands),
        .raw_mem    (raw_mem),
        .misaligned (misaligned)
    );

    csr_file csr_file_i (
        .clock           (clock),
        .reset           (reset),
        .op              (issue.op),
        .cfg_addr        (issue.literal[15:0]),
        .write_value     (operands.a),
        .write_en        (write_en),
        .trap_cmd        (trap_cmd),
        .read_value      (read_value),
        .epc             (epc),
        .status          (),
        .supervisor_mode (supervisor_mode)
    );

    trap_ctrl #(
        .EXC_VECTOR (EXC_VECTOR)
    ) trap_ctrl_i (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .operands      (operands),
        .alu_value     (alu_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .raw_mem       (raw_mem),
        .misaligned    (misaligned),
        .read_value    (read_value),
        .epc           (epc),
        .trap_cmd      (trap_cmd),
        .write_en      (write_en),
        .mem_req       (mem_req),
        .result        (result)
    );

endmodule

//--- trap/trap_ctrl.sv
module trap_ctrl #(
    parameter logic [exec_pkg::XLEN-1:0] EXC_VECTOR = 32'h0000_0100
) (
    input  logic                      clock,
    input  logic                      reset,
    input  exec_pkg::issue_t          issue,
    input  exec_pkg::operands_t       operands,
    input  logic [exec_pkg::XLEN-1:0] alu_value,
    input  logic                      branch_taken,
    input  logic [exec_pkg::XLEN-1:0] branch_target,
    input  exec_pkg::mem_req_t        raw_mem,
    input  logic                      misaligned,
    input  logic [exec_pkg::XLEN-1:0] read_value,
    input  logic [exec_pkg::XLEN-1:0] epc,
    output exec_pkg::trap_cmd_t       trap_cmd,
    output logic                      write_en,
    output exec_pkg::mem_req_t        mem_req,
    output exec_pkg::result_t         result
);
    import exec_pkg::*;

    logic             nullify;
    logic             illegal;
    logic             align_fault;
    logic             syscall;
    logic             exception;
    logic             is_rte;
    cause_e           cause;
    logic [XLEN-1:0]  edata;
    logic [REG_W-1:0] next_dest;
    logic             next_jump;
    logic [XLEN-1:0]  next_jump_addr;
    logic [XLEN-1:0]  next_alu_result;

    // Slot after a taken jump is dead
    assign nullify     = result.jump | reset;
    assign illegal     = !nullify && (issue.op == OP_ILLEGAL);
    assign align_fault = !nullify && misaligned;
    assign syscall     = !nullify && (issue.op == OP_SYSCALL);
    assign exception   = illegal | align_fault | syscall;
    assign is_rte      = !nullify && (issue.op == OP_RTE);

    always_comb begin
        if (illegal) begin
            cause = CAUSE_ILLEGAL_INSTR;
            edata = issue.instr;
        end else if (align_fault) begin
            cause = issue.op[3] ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
            edata = raw_mem.addr;                   // Faulting address
        end else begin
            cause = CAUSE_SYSCALL;
            edata = issue.literal;
        end
    end

    always_comb begin
        trap_cmd.take_trap = exception;
        trap_cmd.cause     = cause;
        trap_cmd.edata     = edata;
        trap_cmd.epc       = issue.pc - 32'd4;      // Faulting instruction
        trap_cmd.rte       = is_rte;
    end

    assign write_en = !nullify && !exception;

    always_comb begin
        mem_req = raw_mem;
        if (!raw_mem.write) begin
            mem_req.wdata.load_tag.latent_dest = issue.latent_dest;
        end
        mem_req.request = raw_mem.request && !nullify && !exception;
    end

    // Jump merge, exceptions first
    always_comb begin
        if (exception) begin
            next_jump      = 1'b1;
            next_jump_addr = EXC_VECTOR;
        end else if (is_rte) begin
            next_jump      = 1'b1;
            next_jump_addr = epc;
        end else begin
            next_jump      = !nullify && branch_taken;
            next_jump_addr = branch_target;
        end
    end

    always_comb begin
        case (issue.op)
            OP_CFGR,
            OP_CFGW: next_alu_result = read_value;  // CFGW returns the old value
            OP_STB,
            OP_STH,
            OP_STW:  next_alu_result = operands.b;  // Store data carried onward
            default: next_alu_result = alu_value;
        endcase
    end

    assign next_dest = (nullify || exception || issue.op == OP_NOP) ? '0 : issue.dest;

    always_ff @(posedge clock) begin
        result.op         <= issue.op;
        result.alu_result <= next_alu_result;
        result.jump_addr  <= next_jump_addr;
        if (reset) begin
            result.jump      <= 1'b0;
            result.dest      <= '0;
            result.dest_zero <= 1'b1;
        end else begin
            result.jump      <= next_jump;
            result.dest      <= next_dest;
            result.dest_zero <= (next_dest == '0);
        end
    end

endmodule

//--- trap/csr_file.sv
module csr_file (
    input  logic                      clock,
    input  logic                      reset,
    input  exec_pkg::op_e             op,
    input  logic [15:0]               cfg_addr,
    input  logic [exec_pkg::XLEN-1:0] write_value,
    input  logic                      write_en,
    input  exec_pkg::trap_cmd_t       trap_cmd,
    output logic [exec_pkg::XLEN-1:0] read_value,
    output logic [exec_pkg::XLEN-1:0] epc,
    output logic [3:0]                status,
    output logic                      supervisor_mode
);
    import exec_pkg::*;

    logic [3:0]      ecause;
    logic [XLEN-1:0] edata;
    logic [3:0]      estatus;
    logic [XLEN-1:0] escratch;
    logic            cfg_write;

    assign cfg_write = write_en && (op == OP_CFGW);

    always_ff @(posedge clock) begin
        if (reset) begin
            status   <= STATUS_SUPERVISOR;  // Start in supervisor mode
            estatus  <= '0;
            ecause   <= '0;
            epc      <= '0;
            edata    <= '0;
            escratch <= '0;
        end else if (trap_cmd.take_trap) begin
            ecause  <= trap_cmd.cause;
            edata   <= trap_cmd.edata;
            epc     <= trap_cmd.epc;
            estatus <= status;                      // Saved for RTE
            status  <= status | STATUS_SUPERVISOR;
        end else if (trap_cmd.rte) begin
            status <= estatus;
        end else if (cfg_write) begin
            case (cfg_addr)
                CFG_ADDR_EPC:      epc      <= write_value;
                CFG_ADDR_ECAUSE:   ecause   <= write_value[3:0];
                CFG_ADDR_EDATA:    edata    <= write_value;
                CFG_ADDR_ESTATUS:  estatus  <= write_value[3:0];
                CFG_ADDR_ESCRATCH: escratch <= write_value;
                default:           ;        // VERSION and unknown are read only
            endcase
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_ADDR_VERSION:  read_value = CFG_VERSION;
            CFG_ADDR_EPC:      read_value = epc;
            CFG_ADDR_ECAUSE:   read_value = {{(XLEN-4){1'b0}}, ecause};
            CFG_ADDR_EDATA:    read_value = edata;
            CFG_ADDR_ESTATUS:  read_value = {{(XLEN-4){1'b0}}, estatus};
            CFG_ADDR_ESCRATCH: read_value = escratch;
            default:           read_value = '0;
        endcase
    end

    assign supervisor_mode = |(status & STATUS_SUPERVISOR);

endmodule

//--- lsu/lsu_agu.sv
module lsu_agu (
    input  exec_pkg::op_e             op,
    input  logic [exec_pkg::XLEN-1:0] literal,
    input  exec_pkg::operands_t       operands,
    output exec_pkg::mem_req_t        raw_mem,
    output logic                      misaligned
);
    import exec_pkg::*;

    logic [XLEN-1:0] addr;
    logic [1:0]      offset;
    logic [1:0]      size;
    logic            is_load;
    logic            is_store;
    logic            bad_align;
    load_tag_t       tag;

    assign addr     = operands.a + literal;
    assign offset   = addr[1:0];
    assign is_load  = op inside {OP_LDB, OP_LDH, OP_LDW};
    assign is_store = op inside {OP_STB, OP_STH, OP_STW};

    always_comb begin
        case (op)
            OP_LDH,
            OP_STH:  size = 2'b01;
            OP_LDW,
            OP_STW:  size = 2'b10;
            default: size = 2'b00;
        endcase
    end

    always_comb begin
        case (size)
            2'b01:   bad_align = offset[0];    // Halfword on odd byte
            2'b10:   bad_align = |offset;
            default: bad_align = 1'b0;
        endcase
    end

    assign misaligned = (is_load || is_store) && bad_align;

    // Latent dest is merged in later by trap_ctrl
    always_comb begin
        tag             = '0;
        tag.size        = size;
        tag.offset      = offset;
    end

    always_comb begin
        raw_mem.request = (is_load || is_store) && !bad_align;
        raw_mem.write   = is_store;
        raw_mem.addr    = addr;
        raw_mem.wdata   = '0;
        raw_mem.wstrb   = 4'b0000;

        if (is_store) begin
            case (size)
                2'b00: begin
                    raw_mem.wdata.store_data = {4{operands.b[7:0]}};
                    raw_mem.wstrb            = 4'b0001 << offset;
                end
                2'b01: begin
                    raw_mem.wdata.store_data = {2{operands.b[15:0]}};
                    raw_mem.wstrb            = offset[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    raw_mem.wdata.store_data = operands.b;
                    raw_mem.wstrb            = 4'b1111;
                end
            endcase
        end else begin
            raw_mem.wdata.load_tag = tag;
        end
    end

endmodule

//--- alu/int_alu.sv
module int_alu (
    input  exec_pkg::issue_t          issue,
    input  exec_pkg::bypass_t         bypass,
    input  logic [exec_pkg::XLEN-1:0] p4_alu_result,
    input  logic [exec_pkg::XLEN-1:0] p5_result,
    output exec_pkg::operands_t       operands,
    output logic [exec_pkg::XLEN-1:0] alu_value,
    output logic                      branch_taken,
    output logic [exec_pkg::XLEN-1:0] branch_target
);
    import exec_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN:0]   diff;
    logic            clt;
    logic            cltu;
    logic [4:0]      shamt;
    logic [XLEN-1:0] pc_rel;

    // Stage 4 is newer than stage 5, so it wins
    always_comb begin
        if (bypass.a4) begin
            a = p4_alu_result;
        end else if (bypass.a5) begin
            a = p5_result;
        end else begin
            a = issue.data_a;
        end

        if (bypass.b4) begin
            b = p4_alu_result;
        end else if (bypass.b5) begin
            b = p5_result;
        end else begin
            b = issue.data_b;
        end
    end

    assign operands = '{a: a, b: b};

    assign diff   = {1'b0, a} - {1'b0, b};             // One subtractor for SUB and compares
    assign cltu   = diff[XLEN];                          // Borrow out
    assign clt    = diff[XLEN] ^ a[XLEN-1] ^ b[XLEN-1];  // Borrow corrected by signs
    assign shamt  = b[4:0];
    assign pc_rel = issue.pc + issue.literal;

    always_comb begin
        case (issue.op)
            OP_AND:   alu_value = a & b;
            OP_OR:    alu_value = a | b;
            OP_XOR:   alu_value = a ^ b;
            OP_SHIFT: begin
                case (issue.literal[6:5])
                    2'b00:   alu_value = a << shamt;           // LSL
                    2'b10:   alu_value = a >> shamt;           // LSR
                    2'b11:   alu_value = $signed(a) >>> shamt; // ASR
                    default: alu_value = '0;
                endcase
            end
            OP_ADD:   alu_value = a + b;
            OP_SUB:   alu_value = diff[XLEN-1:0];
            OP_CLT:   alu_value = {{(XLEN-1){1'b0}}, clt};
            OP_CLTU:  alu_value = {{(XLEN-1){1'b0}}, cltu};
            OP_JAL,
            OP_JALR:  alu_value = issue.pc;                    // Link value
            OP_LDIMM: alu_value = issue.literal;
            OP_LDPC:  alu_value = pc_rel;
            default:  alu_value = '0;
        endcase
    end

    always_comb begin
        case (issue.op)
            OP_BEQ:  branch_taken = (a == b);
            OP_BNE:  branch_taken = (a != b);
            OP_BLT:  branch_taken = clt;
            OP_BGE:  branch_taken = !clt;
            OP_BLTU: branch_taken = cltu;
            OP_BGEU: branch_taken = !cltu;
            OP_JAL,
            OP_JALR: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = (issue.op == OP_JALR) ? a + issue.literal : pc_rel;

endmodule

//--- common/exec_pkg.sv
package exec_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // Store opcodes have bit 3 set, loads have it clear
    typedef enum logic [5:0] {
        OP_AND     = 6'h00,
        OP_OR      = 6'h01,
        OP_XOR     = 6'h02,
        OP_SHIFT   = 6'h03,
        OP_ADD     = 6'h04,
        OP_SUB     = 6'h05,
        OP_CLT     = 6'h06,
        OP_CLTU    = 6'h07,
        OP_LDIMM   = 6'h08,
        OP_LDPC    = 6'h09,
        OP_LDB     = 6'h10,
        OP_LDH     = 6'h11,
        OP_LDW     = 6'h12,
        OP_STB     = 6'h18,
        OP_STH     = 6'h19,
        OP_STW     = 6'h1a,
        OP_BEQ     = 6'h20,
        OP_BNE     = 6'h21,
        OP_BLT     = 6'h22,
        OP_BGE     = 6'h23,
        OP_BLTU    = 6'h24,
        OP_BGEU    = 6'h25,
        OP_JAL     = 6'h26,
        OP_JALR    = 6'h27,
        OP_CFGR    = 6'h30,
        OP_CFGW    = 6'h31,
        OP_RTE     = 6'h32,
        OP_SYSCALL = 6'h33,
        OP_ILLEGAL = 6'h3e,
        OP_NOP     = 6'h3f
    } op_e;

    typedef enum logic [3:0] {
        CAUSE_ILLEGAL_INSTR    = 4'd2,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_SYSCALL          = 4'd8
    } cause_e;

    typedef enum logic [15:0] {
        CFG_ADDR_VERSION  = 16'h0000,
        CFG_ADDR_EPC      = 16'h0001,
        CFG_ADDR_ECAUSE   = 16'h0002,
        CFG_ADDR_EDATA    = 16'h0003,
        CFG_ADDR_ESTATUS  = 16'h0004,
        CFG_ADDR_ESCRATCH = 16'h0005
    } cfg_addr_e;

    localparam logic [3:0]      STATUS_SUPERVISOR = 4'b0001;
    localparam logic [XLEN-1:0] CFG_VERSION       = 32'h0001_0000;  // Version 1.0

    typedef struct packed {
        logic [XLEN-1:0]  pc;           // Address of the next instruction
        logic [XLEN-1:0]  instr;
        op_e              op;
        logic [XLEN-1:0]  literal;
        logic [REG_W-1:0] dest;
        logic [REG_W-1:0] latent_dest;  // Load target, written by a later stage
        logic [XLEN-1:0]  data_a;
        logic [XLEN-1:0]  data_b;
    } issue_t;

    typedef struct packed {
        logic a4;
        logic b4;
        logic a5;
        logic b5;
    } bypass_t;

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } operands_t;

    typedef struct packed {
        logic [XLEN-10:0] pad;
        logic [1:0]       size;         // 0 byte, 1 half, 2 word
        logic [1:0]       offset;
        logic [REG_W-1:0] latent_dest;
    } load_tag_t;

    // Write data of a store, or the tag of a load
    typedef union packed {
        logic [XLEN-1:0] store_data;
        load_tag_t       load_tag;
    } mem_word_u;

    typedef struct packed {
        logic            request;
        logic            write;
        logic [XLEN-1:0] addr;
        mem_word_u       wdata;
        logic [3:0]      wstrb;
    } mem_req_t;

    typedef struct packed {
        logic            take_trap;
        cause_e          cause;
        logic [XLEN-1:0] edata;
        logic [XLEN-1:0] epc;
        logic            rte;
    } trap_cmd_t;

    typedef struct packed {
        op_e              op;
        logic [REG_W-1:0] dest;
        logic             dest_zero;
        logic [XLEN-1:0]  alu_result;
        logic             jump;
        logic [XLEN-1:0]  jump_addr;
    } result_t;

endpackage
